//--- alu/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module alu (
    input  wire logic [`DATA_W-1:0] a,
    input  wire logic [`DATA_W-1:0] b,
    input  wire logic               carry_in,
    input  wire isa_pkg::alu_op_t   alu_op,
    output logic [`DATA_W-1:0]      result,
    output logic                    carry_out,
    output logic                    overflow
);
    import isa_pkg::*;

    logic               subtract;
    logic               carry_add;
    logic [`DATA_W-1:0] b_add;  // Second adder operand
    logic [`DATA_W:0]   sum;    // Sum with carry bit on top

    assign subtract  = (alu_op == SBC) || (alu_op == CMP);
    assign b_add     = subtract ? ~b : b;           // Subtract as add of complement
    assign carry_add = (alu_op == CMP) ? 1'b1 : carry_in;
    assign sum       = {1'b0, a} + {1'b0, b_add} + {{`DATA_W{1'b0}}, carry_add};
    assign carry_out = sum[`DATA_W];

    // Signed overflow when like-signed operands give a different sign
    assign overflow = (a[`DATA_W-1] == b_add[`DATA_W-1])
                      && (sum[`DATA_W-1] != a[`DATA_W-1]);

    always_comb
    begin
        case (alu_op)
            ORA:     result = a | b;
            AND:     result = a & b;
            EOR:     result = a ^ b;
            default: result = sum[`DATA_W-1:0]; // ADC SBC CMP
        endcase
    end

endmodule

`default_nettype wire

//--- bench/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu_core;

    localparam int NUM_INSTR    = 40;     // Random instructions before the closing JMP
    localparam int NUM_SYNC     = 400;    // Fetches to observe
    localparam int MAX_CYCLES   = 20000;
    localparam int SYNC_TIMEOUT = 40;     // Cycles allowed between fetches
    localparam logic [15:0] PROG_START = 16'h0400;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        logic        n;
        logic        v;
        logic        z;
        logic        c;
        logic [15:0] pc;
    } cpu_state_t;

    typedef struct packed {
        cpu_state_t  s;
        logic        wr;      // Instruction stores a byte
        logic [15:0] wr_addr;
        logic [7:0]  wr_data;
    } step_result_t;

    logic                clock;
    logic                reset;
    logic                enable;
    logic [`DATA_W-1:0]  data_pins;
    logic [`ADDR_W-1:0]  address;
    logic [`DATA_W-1:0]  data_out;
    logic                write_enable;
    logic                sync;
    logic [`DATA_W-1:0]  debug_opcode;
    logic [`DATA_W-1:0]  debug_a;
    logic [`DATA_W-1:0]  debug_x;
    logic [`DATA_W-1:0]  debug_y;
    logic [`DATA_W-1:0]  debug_status;
    logic [`ADDR_W-1:0]  debug_pc;

    logic [7:0]   mem [0:65535];        // Memory seen by the DUT
    logic [7:0]   model_mem [0:65535];  // Memory of the reference model
    logic [7:0]   opcode_table [0:34];
    cpu_state_t   model;
    cpu_state_t   exp_state;            // State due in the cycle after a fetch
    step_result_t step;
    logic [7:0]   exp_opcode;
    logic         check_after_sync;
    logic         expect_write;
    logic         write_seen;
    int           startup_count;
    int           sync_count;
    int           since_sync;
    int           reset_count;
    logic         prev_valid;
    logic         prev_enable;
    logic [15:0]  prev_address;
    logic [15:0]  prev_pc;
    logic [39:0]  prev_debug;           // Opcode, A, X, Y and status

    cpu_core u_cpu_core (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_pins    (data_pins),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync),
        .debug_opcode (debug_opcode),
        .debug_a      (debug_a),
        .debug_x      (debug_x),
        .debug_y      (debug_y),
        .debug_status (debug_status),
        .debug_pc     (debug_pc)
    );

    assign data_pins = mem[address];  // Asynchronous read

    always #20 clock = ~clock;

    always @(posedge clock)
    begin
        if (write_enable && enable)
            mem[address] <= data_out;
    end

    function automatic logic [7:0] random_byte();
        logic [31:0] w;
        begin
            w = $urandom;
            return w[7:0];
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("%0t %s", $time, msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input logic [`DATA_W-1:0] exp,
                                input logic [`DATA_W-1:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic compare_address(input string name, input logic [`ADDR_W-1:0] exp,
                                   input logic [`ADDR_W-1:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic compare_opcode(input string name, input isa_pkg::opcode_t exp,
                                  input isa_pkg::opcode_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp.raw, act.raw);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // One instruction by the 6502 rules, binary arithmetic only
    function automatic step_result_t model_step(cpu_state_t s);
        step_result_t r;
        logic [7:0]   opc;
        logic [7:0]   lo;
        logic [7:0]   hi;
        logic [7:0]   m;
        logic [7:0]   res;
        int           u_res;  // Result as unsigned integers
        int           s_res;  // Result as signed integers
        logic [15:0]  ea;
        logic [2:0]   mode;   // 0 imm, 1 zp, 2 abs, 3 implied, 4 jmp
        logic         set_nz;
        begin
            opc    = model_mem[s.pc];
            lo     = model_mem[s.pc + 16'd1];
            hi     = model_mem[s.pc + 16'd2];
            r.s    = s;
            r.wr   = 1'b0;
            r.wr_addr = 16'h0000;
            r.wr_data = 8'h00;
            set_nz = 1'b0;
            res    = 8'h00;
            case (opc)
                8'h18, 8'h38: mode = 3'd3;
                8'h4c:        mode = 3'd4;
                8'ha9, 8'ha2, 8'ha0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9:
                    mode = 3'd0;
                8'ha5, 8'ha6, 8'ha4, 8'h85, 8'h86, 8'h84, 8'h05, 8'h25, 8'h45,
                8'h65, 8'hc5, 8'he5:
                    mode = 3'd1;
                default: mode = 3'd2;
            endcase
            ea = (mode == 3'd1) ? {8'h00, lo} : {hi, lo};
            m  = (mode == 3'd0) ? lo : model_mem[ea];
            case (mode)
                3'd0, 3'd1: r.s.pc = s.pc + 16'd2;
                3'd2:       r.s.pc = s.pc + 16'd3;
                3'd3:       r.s.pc = s.pc + 16'd1;
                default:    r.s.pc = {hi, lo};  // Jump target
            endcase
            case (opc)
                8'h18: r.s.c = 1'b0;
                8'h38: r.s.c = 1'b1;
                8'ha9, 8'ha5, 8'had:
                begin
                    r.s.a  = m;
                    res    = m;
                    set_nz = 1'b1;
                end
                8'ha2, 8'ha6, 8'hae:
                begin
                    r.s.x  = m;
                    res    = m;
                    set_nz = 1'b1;
                end
                8'ha0, 8'ha4, 8'hac:
                begin
                    r.s.y  = m;
                    res    = m;
                    set_nz = 1'b1;
                end
                8'h85, 8'h8d:
                begin
                    r.wr      = 1'b1;
                    r.wr_addr = ea;
                    r.wr_data = s.a;
                end
                8'h86, 8'h8e:
                begin
                    r.wr      = 1'b1;
                    r.wr_addr = ea;
                    r.wr_data = s.x;
                end
                8'h84, 8'h8c:
                begin
                    r.wr      = 1'b1;
                    r.wr_addr = ea;
                    r.wr_data = s.y;
                end
                8'h09, 8'h05, 8'h0d:
                begin
                    res    = s.a | m;
                    r.s.a  = res;
                    set_nz = 1'b1;
                end
                8'h29, 8'h25, 8'h2d:
                begin
                    res    = s.a & m;
                    r.s.a  = res;
                    set_nz = 1'b1;
                end
                8'h49, 8'h45, 8'h4d:
                begin
                    res    = s.a ^ m;
                    r.s.a  = res;
                    set_nz = 1'b1;
                end
                8'h69, 8'h65, 8'h6d:
                begin
                    u_res  = int'(s.a) + int'(m) + int'(s.c);
                    s_res  = int'($signed(s.a)) + int'($signed(m)) + int'(s.c);
                    res    = u_res[7:0];
                    r.s.a  = res;
                    r.s.c  = (u_res > 255);  // Unsigned carry out
                    r.s.v  = (s_res > 127) || (s_res < -128);
                    set_nz = 1'b1;
                end
                8'he9, 8'he5, 8'hed:
                begin
                    // Clear carry means borrow one more
                    u_res  = int'(s.a) - int'(m) - (1 - int'(s.c));
                    s_res  = int'($signed(s.a)) - int'($signed(m)) - (1 - int'(s.c));
                    res    = u_res[7:0];
                    r.s.a  = res;
                    r.s.c  = (u_res >= 0);   // Set when no borrow
                    r.s.v  = (s_res > 127) || (s_res < -128);
                    set_nz = 1'b1;
                end
                8'hc9, 8'hc5, 8'hcd:
                begin
                    u_res  = int'(s.a) - int'(m);
                    res    = u_res[7:0];
                    r.s.c  = (u_res >= 0);  // Set when A >= M
                    set_nz = 1'b1;
                end
                default: ;
            endcase
            if (set_nz)
            begin
                r.s.n = res[7];
                r.s.z = (res == 8'h00);
            end
            return r;
        end
    endfunction

    // Memory fill, random data pages and a random program
    task automatic build_memory();
        logic [15:0] pc;
        logic [31:0] w;
        int          idx;
        opcode_table = '{8'ha9, 8'ha2, 8'ha0, 8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9,
                         8'ha5, 8'ha6, 8'ha4, 8'h85, 8'h86, 8'h84, 8'h05, 8'h25, 8'h45,
                         8'h65, 8'hc5, 8'he5,
                         8'had, 8'hae, 8'hac, 8'h8d, 8'h8e, 8'h8c, 8'h0d, 8'h2d, 8'h4d,
                         8'h6d, 8'hcd, 8'hed,
                         8'h18, 8'h38};
        for (int i = 0; i < 65536; i++)
        begin
            w = i;
            mem[i] = w[15:8] ^ w[7:0] ^ 8'h5a;  // Depends on both address bytes
        end
        for (int i = 0; i < 256; i++)
        begin
            mem[i]            = random_byte();  // Zero page
            mem[16'h0200 + i] = random_byte();
        end
        pc = PROG_START;
        for (int i = 0; i < NUM_INSTR; i++)
        begin
            w   = $urandom;
            idx = int'(w % 32'd35);
            mem[pc] = opcode_table[idx];
            if (idx < 21)
            begin
                mem[pc + 16'd1] = random_byte();  // Immediate or zero-page operand
                pc = pc + 16'd2;
            end
            else if (idx < 33)
            begin
                mem[pc + 16'd1] = random_byte();
                mem[pc + 16'd2] = 8'h02;          // Operand on page 02
                pc = pc + 16'd3;
            end
            else
                pc = pc + 16'd1;
        end
        mem[pc]         = `OPC_JMP_ABS;  // Loop back to the start
        mem[pc + 16'd1] = PROG_START[7:0];
        mem[pc + 16'd2] = PROG_START[15:8];
        mem[16'hfffc]   = PROG_START[7:0];
        mem[16'hfffd]   = PROG_START[15:8];
        for (int i = 0; i < 65536; i++)
            model_mem[i] = mem[i];
    endtask

    // Reset for 8 cycles, then random enable 2 ns after each edge
    always @(posedge clock)
    begin
        logic [31:0] w;
        #2;
        if (reset_count < 8)
        begin
            reset_count = reset_count + 1;
            if (reset_count == 8)
                reset = 1'b0;
        end
        else
        begin
            w      = $urandom;
            enable = (w[1:0] != 2'b00);  // Low one cycle in four
        end
    end

    // Compare process sampled mid-cycle
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (prev_valid && !prev_enable)
            begin
                // Stalled cycle must leave everything frozen
                compare_address("address", prev_address, address);
                compare_address("debug_pc", prev_pc, debug_pc);
                compare_byte("debug_opcode", prev_debug[39:32], debug_opcode);
                compare_byte("debug_a", prev_debug[31:24], debug_a);
                compare_byte("debug_x", prev_debug[23:16], debug_x);
                compare_byte("debug_y", prev_debug[15:8], debug_y);
                compare_byte("debug_status", prev_debug[7:0], debug_status);
            end
            since_sync = since_sync + 1;
            if (since_sync > SYNC_TIMEOUT)
                report_failure("no opcode fetch seen within the cycle limit");
            if (enable)
            begin
                if (check_after_sync)
                begin
                    compare_opcode("debug_opcode", exp_opcode, debug_opcode);
                    compare_byte("debug_a", exp_state.a, debug_a);
                    compare_byte("debug_x", exp_state.x, debug_x);
                    compare_byte("debug_y", exp_state.y, debug_y);
                    compare_byte("debug_status", {exp_state.n, exp_state.v, 4'b1100,
                                 exp_state.z, exp_state.c}, debug_status);
                    check_after_sync = 1'b0;
                end
                if (startup_count < 2)
                begin
                    // Vector read as low byte then high byte
                    compare_address("address", `RESET_VECTOR + 16'(startup_count), address);
                    if (sync)
                        report_failure("sync high while the reset vector is read");
                    startup_count = startup_count + 1;
                end
                else if (sync)
                begin
                    if (expect_write && !write_seen)
                        report_failure("expected store did not happen before the next fetch");
                    compare_address("address", model.pc, address);
                    compare_address("debug_pc", model.pc, debug_pc);
                    exp_state        = model;
                    exp_opcode       = model_mem[model.pc];
                    check_after_sync = 1'b1;
                    step             = model_step(model);
                    model            = step.s;
                    expect_write     = step.wr;
                    write_seen       = 1'b0;
                    if (step.wr)
                        model_mem[step.wr_addr] = step.wr_data;
                    since_sync = 0;
                    sync_count = sync_count + 1;
                end
                if (write_enable)
                begin
                    if (!expect_write || write_seen)
                        report_failure("memory write that the program does not contain");
                    compare_address("address", step.wr_addr, address);
                    compare_byte("data_out", step.wr_data, data_out);
                    write_seen = 1'b1;
                end
            end
            prev_valid   = 1'b1;
            prev_enable  = enable;
            prev_address = address;
            prev_pc      = debug_pc;
            prev_debug   = {debug_opcode, debug_a, debug_x, debug_y, debug_status};
        end
    end

    initial
    begin
        int cycles;
        void'($urandom(32'hdda0));
        clock            = 1'b0;
        reset            = 1'b1;
        enable           = 1'b1;
        reset_count      = 0;
        startup_count    = 0;
        sync_count       = 0;
        since_sync       = 0;
        check_after_sync = 1'b0;
        expect_write     = 1'b0;
        write_seen       = 1'b0;
        prev_valid       = 1'b0;
        prev_enable      = 1'b1;
        build_memory();
        model    = '0;  // Reset clears registers and flags
        model.pc = {model_mem[16'hfffd], model_mem[16'hfffc]};
        step     = '0;
        cycles   = 0;
        while (sync_count < NUM_SYNC && cycles < MAX_CYCLES)
        begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        if (sync_count >= NUM_SYNC)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            $display("timeout after %0d cycles with %0d fetches", cycles, sync_count);
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data bus width
`define DATA_W 8

// Address bus width
`define ADDR_W 16

// Address of the low byte of the start vector
`define RESET_VECTOR 16'hfffc

// High address byte in zero-page cycles
`define ZERO_PAGE_HIGH 8'h00

// JMP absolute opcode that reset forces into the opcode register
`define OPC_JMP_ABS 8'h4c

`endif

//--- common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // One-hot cycle state
    typedef struct packed {
        logic byte1;    // Opcode fetch, sync high
        logic byte2;    // First operand byte
        logic byte3;    // High operand byte
        logic zeropage; // Data access in page 00
        logic absolute; // Data access at a 16-bit address
    } cycle_state_t;

    typedef enum logic [1:0] {PC, ZERO_PAGE, ABSOLUTE} addr_sel_t;

    // Write-back target or store source
    typedef enum logic [1:0] {NONE, A, X, Y} reg_sel_t;

    typedef enum logic [2:0] {
        KEEP,         // Flags unchanged
        NZ,           // Loads and logic ops
        NZC,          // Compare
        NZCV,         // Add and subtract
        C_FROM_OPCODE // CLC and SEC
    } flag_mode_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Opcode split as aaa bbb cc
    typedef struct packed {
        logic [2:0] aaa; // Operation
        logic [2:0] bbb; // Addressing mode
        logic [1:0] cc;  // Instruction group
    } opcode_fields_t;

    // One opcode byte read raw or by field
    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_t;

    // Values follow the aaa field of group 01
    typedef enum logic [2:0] {
        ORA = 3'b000, // Bitwise or
        AND = 3'b001, // Bitwise and
        EOR = 3'b010, // Bitwise xor
        ADC = 3'b011, // Add with carry
        CMP = 3'b110, // Subtract with carry forced, no write-back
        SBC = 3'b111  // Subtract with borrow
    } alu_op_t;

endpackage

`default_nettype wire

//--- control/cycle_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cycle_control (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               enable,
    input  wire logic [`DATA_W-1:0] data_pins,
    output isa_pkg::opcode_t        opcode,
    output ctrl_pkg::addr_sel_t     addr_sel,
    output logic                    pc_inc,
    output logic                    pc_load,
    output ctrl_pkg::reg_sel_t      dest_sel,
    output ctrl_pkg::reg_sel_t      store_sel,
    output ctrl_pkg::flag_mode_t    flag_mode,
    output isa_pkg::alu_op_t        alu_op,
    output logic                    write_enable,
    output logic                    sync
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    cycle_state_t state;
    cycle_state_t next_state;
    reg_sel_t     group_reg;  // Register named by the cc field
    logic         is_load;
    logic         is_store;
    logic         is_alu;
    logic         is_jmp;
    logic         is_flag_op;
    logic         mode_zp;
    logic         mode_abs;

    // Opcode classes
    assign is_load    = (opcode.f.aaa == 3'b101);  // LDA LDX LDY
    assign is_store   = (opcode.f.aaa == 3'b100);  // STA STX STY
    assign is_alu     = (opcode.f.cc == 2'b01) && !is_load && !is_store;
    assign is_jmp     = (opcode.raw == `OPC_JMP_ABS);
    assign mode_zp    = (opcode.f.bbb == 3'b001);
    assign mode_abs   = (opcode.f.bbb == 3'b011);  // Includes JMP
    // CLC and SEC, the only implied opcodes
    assign is_flag_op = (opcode.f.aaa[2:1] == 2'b00) && (opcode.f.bbb == 3'b110)
                        && (opcode.f.cc == 2'b00);

    always_comb
    begin
        case (opcode.f.cc)
            2'b01:   group_reg = A;
            2'b10:   group_reg = X;
            2'b00:   group_reg = Y;
            default: group_reg = NONE;
        endcase
    end

    // ALU operation straight from aaa
    always_comb
    begin
        case (opcode.f.aaa)
            3'b000:  alu_op = ORA;
            3'b001:  alu_op = AND;
            3'b010:  alu_op = EOR;
            3'b011:  alu_op = ADC;
            3'b110:  alu_op = CMP;
            3'b111:  alu_op = SBC;
            default: alu_op = ORA; // Loads and stores never use it
        endcase
    end

    always_comb
    begin
        next_state   = '0;
        addr_sel     = PC;
        pc_inc       = 1'b0;
        pc_load      = 1'b0;
        dest_sel     = NONE;
        store_sel    = NONE;
        flag_mode    = KEEP;
        write_enable = 1'b0;

        if (state.byte1)
        begin
            next_state.byte2 = 1'b1;
            pc_inc           = 1'b1;
            // Opcode register still holds the previous instruction here
            if (is_load)
            begin
                dest_sel  = group_reg;
                flag_mode = NZ;
            end
            else if (is_alu)
            begin
                dest_sel = (alu_op == CMP) ? NONE : A;  // CMP only sets flags
                case (alu_op)
                    ADC, SBC: flag_mode = NZCV;
                    CMP:      flag_mode = NZC;
                    default:  flag_mode = NZ;
                endcase
            end
            else if (is_flag_op)
                flag_mode = C_FROM_OPCODE;
        end

        if (state.byte2)
        begin
            pc_inc = !is_flag_op;  // Implied opcodes reread this byte
            if (mode_zp)
                next_state.zeropage = 1'b1;
            else if (mode_abs)
                next_state.byte3 = 1'b1;
            else
                next_state.byte1 = 1'b1; // Immediate or implied
        end

        if (state.byte3)
        begin
            pc_load = is_jmp;  // Target is high byte on pins, low in data_reg
            pc_inc  = !is_jmp;
            if (is_jmp)
                next_state.byte1 = 1'b1;
            else
                next_state.absolute = 1'b1;
        end

        // Final data cycle of zero-page and absolute forms
        if (state.zeropage || state.absolute)
        begin
            addr_sel         = state.zeropage ? ZERO_PAGE : ABSOLUTE;
            next_state.byte1 = 1'b1;
            if (is_store)
            begin
                write_enable = 1'b1;
                store_sel    = group_reg;
            end
        end
    end

    assign sync = state.byte1;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            // Resume inside a JMP absolute that reads the vector
            state  <= '{byte2: 1'b1, default: 1'b0};
            opcode <= `OPC_JMP_ABS;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state.byte1)
                opcode <= data_pins; // Latch fetched opcode
        end
    end

    // Exactly one cycle state at a time
    state_one_hot: assert property (@(posedge clock) disable iff (reset)
        $onehot(state));

    // A store never falls on an opcode fetch
    no_write_on_sync: assert property (@(posedge clock) disable iff (reset)
        !(write_enable && sync));

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
alu/alu.sv
control/cycle_control.sv
source/register_file.sv
source/address_unit.sv
source/cpu_core.sv
bench/tb_cpu_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_cpu_core -o sim_tb_cpu_core
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- source/address_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module address_unit (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                enable,
    input  wire logic [`DATA_W-1:0]  data_pins,
    input  wire logic [`DATA_W-1:0]  data_out,
    input  wire logic                write_enable,
    input  wire ctrl_pkg::addr_sel_t addr_sel,
    input  wire logic                pc_inc,
    input  wire logic                pc_load,
    output logic [`ADDR_W-1:0]       address,
    output logic [`DATA_W-1:0]       data_reg,
    output logic [`ADDR_W-1:0]       pc
);
    import ctrl_pkg::*;

    logic [`DATA_W-1:0] operand_low;  // Low address byte of absolute forms

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= `RESET_VECTOR;
        else if (enable)
        begin
            if (pc_load)
                pc <= {data_pins, data_reg}; // JMP target
            else if (pc_inc)
                pc <= pc + {{(`ADDR_W-1){1'b0}}, 1'b1};
        end
    end

    // Input register follows the bus every enabled cycle
    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            data_reg    <= write_enable ? data_out : data_pins; // Written byte on stores
            operand_low <= data_reg;
        end
    end

    always_comb
    begin
        case (addr_sel)
            ZERO_PAGE: address = {`ZERO_PAGE_HIGH, data_reg};
            ABSOLUTE:  address = {data_reg, operand_low};  // High byte just read
            default:   address = pc;
        endcase
    end

    // Load and increment exclude each other
    pc_update_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(pc_inc && pc_load));

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_core (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               enable,
    input  wire logic [`DATA_W-1:0] data_pins,
    output logic [`ADDR_W-1:0]      address,
    output logic [`DATA_W-1:0]      data_out,
    output logic                    write_enable,
    output logic                    sync,
    output logic [`DATA_W-1:0]      debug_opcode,
    output logic [`DATA_W-1:0]      debug_a,
    output logic [`DATA_W-1:0]      debug_x,
    output logic [`DATA_W-1:0]      debug_y,
    output logic [`DATA_W-1:0]      debug_status,
    output logic [`ADDR_W-1:0]      debug_pc
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t            opcode;
    alu_op_t            alu_op;
    addr_sel_t          addr_sel;
    logic               pc_inc;
    logic               pc_load;
    reg_sel_t           dest_sel;
    reg_sel_t           store_sel;
    flag_mode_t         flag_mode;
    logic [`DATA_W-1:0] data_reg;  // Registered input byte

    cycle_control u_cycle_control (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_pins    (data_pins),
        .opcode       (opcode),
        .addr_sel     (addr_sel),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .dest_sel     (dest_sel),
        .store_sel    (store_sel),
        .flag_mode    (flag_mode),
        .alu_op       (alu_op),
        .write_enable (write_enable),
        .sync         (sync)
    );

    address_unit u_address_unit (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_pins    (data_pins),
        .data_out     (data_out),
        .write_enable (write_enable),
        .addr_sel     (addr_sel),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .address      (address),
        .data_reg     (data_reg),
        .pc           (debug_pc)
    );

    register_file u_register_file (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_reg     (data_reg),
        .opcode       (opcode),
        .dest_sel     (dest_sel),
        .store_sel    (store_sel),
        .flag_mode    (flag_mode),
        .alu_op       (alu_op),
        .data_out     (data_out),
        .debug_a      (debug_a),
        .debug_x      (debug_x),
        .debug_y      (debug_y),
        .debug_status (debug_status)
    );

    assign debug_opcode = opcode.raw;

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module register_file (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 enable,
    input  wire logic [`DATA_W-1:0]   data_reg,
    input  wire isa_pkg::opcode_t     opcode,
    input  wire ctrl_pkg::reg_sel_t   dest_sel,
    input  wire ctrl_pkg::reg_sel_t   store_sel,
    input  wire ctrl_pkg::flag_mode_t flag_mode,
    input  wire isa_pkg::alu_op_t     alu_op,
    output logic [`DATA_W-1:0]        data_out,
    output logic [`DATA_W-1:0]        debug_a,
    output logic [`DATA_W-1:0]        debug_x,
    output logic [`DATA_W-1:0]        debug_y,
    output logic [`DATA_W-1:0]        debug_status
);
    import ctrl_pkg::*;

    logic [`DATA_W-1:0] reg_a;
    logic [`DATA_W-1:0] reg_x;
    logic [`DATA_W-1:0] reg_y;
    logic               flag_n;
    logic               flag_v;
    logic               flag_z;
    logic               flag_c;
    logic [`DATA_W-1:0] alu_result;
    logic               alu_carry;
    logic               alu_overflow;
    logic [`DATA_W-1:0] write_value;

    // Accumulator against the fetched operand
    alu u_alu (
        .a         (reg_a),
        .b         (data_reg),
        .carry_in  (flag_c),
        .alu_op    (alu_op),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    // Loads take data_reg unchanged
    assign write_value = (opcode.f.aaa == 3'b101) ? data_reg : alu_result;

    // Store source
    always_comb
    begin
        case (store_sel)
            A:       data_out = reg_a;
            X:       data_out = reg_x;
            Y:       data_out = reg_y;
            default: data_out = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            reg_a  <= '0;
            reg_x  <= '0;
            reg_y  <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (enable)
        begin
            case (dest_sel)
                A:    reg_a <= write_value;
                X:    reg_x <= write_value;
                Y:    reg_y <= write_value;
                NONE: ;  // Stores, compares, jumps
            endcase
            if (flag_mode inside {NZ, NZC, NZCV})
            begin
                flag_n <= write_value[`DATA_W-1];
                flag_z <= (write_value == '0);
            end
            if (flag_mode inside {NZC, NZCV})
                flag_c <= alu_carry;
            if (flag_mode == NZCV)
                flag_v <= alu_overflow;
            if (flag_mode == C_FROM_OPCODE)
                flag_c <= opcode.raw[5]; // 0 for CLC, 1 for SEC
        end
    end

    assign debug_a      = reg_a;
    assign debug_x      = reg_x;
    assign debug_y      = reg_y;
    assign debug_status = {flag_n, flag_v, 2'b11, 2'b00, flag_z, flag_c}; // N V 1 1 0 0 Z C

endmodule

`default_nettype wire
